/* build.f */
design/pad_pkg.sv
design/line_tick.sv
design/pad_scanner.sv
design/press_detect.sv
design/pad_port_top.sv
bench/pad_model.sv
bench/tb_pad_port.sv

/* run.sh */
#!/bin/sh
# build the pad port testbench with verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pad_port -Mdir obj_dir -f build.f \
    && ./obj_dir/Vtb_pad_port > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log && echo "simulation PASSED" && exit 0 \
    || { echo "simulation FAILED"; exit 1; }

/* bench/tb_pad_port.sv */
// testbench for the two-port db9 pad reader that walks a table of pad setups
`timescale 1ns/1ps

module tb_pad_port;
    import pad_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int N_ENTRIES      = 8;
    localparam int IDLE_LINES     = 10;
    localparam int SAMPLE_CYCLES  = SCAN_LINES * LINE_CYCLES;
    // two samples per entry plus room for reset, idle check and startup sample
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 2 * SAMPLE_CYCLES + 3616;

    // rand_btn swaps both button sets for lfsr values
    typedef struct packed {
        pad_kind_t kind0;
        pad_word_t btn0;
        pad_kind_t kind1;
        pad_word_t btn1;
        logic      rand_btn;
    } entry_t;

    logic        clk;
    logic        rst;
    logic        scan;
    pad_lines_t  din;
    logic        split;
    logic        mdsel;
    logic        sample;
    logic        press_evt;
    pad_word_t   joy0;
    pad_word_t   joy1;
    pad_word_t   press0;
    pad_word_t   press1;
    // setup the pads show right now
    pad_kind_t   kind0;
    pad_kind_t   kind1;
    pad_word_t   btn0;
    pad_word_t   btn1;
    entry_t      tbl [N_ENTRIES];
    logic [31:0] lfsr;
    int          cycles = 0;
    int          last_sample;
    // expected words now and at the sample before
    pad_word_t   exp0;
    pad_word_t   exp1;
    pad_word_t   prev0;
    pad_word_t   prev1;

    pad_port_top uut (
        .clk       (clk),
        .rst       (rst),
        .scan      (scan),
        .din       (din),
        .split     (split),
        .mdsel     (mdsel),
        .joy0      (joy0),
        .joy1      (joy1),
        .sample    (sample),
        .press0    (press0),
        .press1    (press1),
        .press_evt (press_evt)
    );

    pad_model u_pads (
        .clk   (clk),
        .split (split),
        .mdsel (mdsel),
        .kind0 (kind0),
        .kind1 (kind1),
        .btn0  (btn0),
        .btn1  (btn1),
        .din   (din)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, no sample arrived within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1, "run stopped by the cycle watchdog");
        end
    end

    // ==================================================================
    // checks
    // ==================================================================

    task automatic check_word(input pad_word_t got, input pad_word_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %03h, expected %03h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ==================================================================
    // stimulus helpers
    // ==================================================================

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic random_buttons(output pad_word_t w);
        w = '0;
        for (int i = 0; i < $bits(pad_word_t); i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
        // a d-pad cannot press up and down together
        if (w[BIT_UP]) begin
            w[BIT_DOWN] = 1'b0;
        end
    endtask

    // six pad keeps everything while a three pad drops X/Y/Z/mode and an absent pad reads zero
    function automatic pad_word_t expect_word(input pad_kind_t k, input pad_word_t b);
        pad_word_t extra;
        extra           = '0;
        extra[BIT_X]    = 1'b1;
        extra[BIT_Y]    = 1'b1;
        extra[BIT_Z]    = 1'b1;
        extra[BIT_MODE] = 1'b1;
        case (k)
            SIX:     return b;
            THREE:   return b & ~extra;
            default: return '0;
        endcase
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // waits for sample, checks spacing, words and the press event one cycle on
    task automatic verify_sample(input string tag, input logic check_gap);
        step();
        while (sample !== 1'b1) begin
            step();
        end
        if (check_gap) begin
            check_strobe(cycles - last_sample == SAMPLE_CYCLES, 1'b1, {tag, " spacing"});
        end
        last_sample = cycles;
        check_strobe(press_evt, 1'b0, {tag, " press_evt early"});
        check_word(joy0, exp0, {tag, " joy0"});
        check_word(joy1, exp1, {tag, " joy1"});
        step();
        check_strobe(sample, 1'b0, {tag, " sample width"});
        check_strobe(press_evt, 1'b1, {tag, " press_evt"});
        check_word(press0, exp0 & ~prev0, {tag, " press0"});
        check_word(press1, exp1 & ~prev1, {tag, " press1"});
        prev0 = exp0;
        prev1 = exp1;
    endtask

    task automatic fill_table();
        // kind0, btn0, kind1, btn1, rand_btn
        tbl[0] = '{SIX,   12'h411, SIX,   12'hA88, 1'b0};
        tbl[1] = '{SIX,   12'h411, SIX,   12'hF7E, 1'b0};
        tbl[2] = '{THREE, 12'hFF6, NONE,  12'h0FF, 1'b0};
        tbl[3] = '{THREE, 12'h000, SIX,   12'h000, 1'b1};
        tbl[4] = '{NONE,  12'h000, THREE, 12'h46A, 1'b0};
        tbl[5] = '{SIX,   12'h000, SIX,   12'h000, 1'b1};
        tbl[6] = '{SIX,   12'h000, SIX,   12'hFFD, 1'b0};
        tbl[7] = '{THREE, 12'h471, THREE, 12'h471, 1'b0};
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================

    initial begin
        rst   = 1'b1;
        scan  = 1'b0;
        kind0 = NONE;
        kind1 = NONE;
        btn0  = '0;
        btn1  = '0;
        lfsr  = 32'h71094022;
        exp0  = '0;
        exp1  = '0;
        prev0 = '0;
        prev1 = '0;
        last_sample = 0;
        fill_table();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // scan off with the connector parked and nothing published
        for (int i = 0; i < IDLE_LINES * LINE_CYCLES; i++) begin
            check_strobe(split, 1'b1, "split idle");
            check_strobe(mdsel, 1'b1, "mdsel idle");
            check_strobe(sample, 1'b0, "sample idle");
            check_word(joy0 | joy1 | press0 | press1, '0, "outputs idle");
            step();
        end
        scan = 1'b1;
        verify_sample("startup", 1'b0);

        for (int e = 0; e < N_ENTRIES; e++) begin
            // old setup once more where held buttons give no press
            verify_sample($sformatf("entry %0d held", e), 1'b1);
            kind0 = tbl[e].kind0;
            kind1 = tbl[e].kind1;
            btn0  = tbl[e].btn0;
            btn1  = tbl[e].btn1;
            if (tbl[e].rand_btn) begin
                random_buttons(btn0);
                random_buttons(btn1);
            end
            exp0 = expect_word(kind0, btn0);
            exp1 = expect_word(kind1, btn1);
            verify_sample($sformatf("entry %0d", e), 1'b1);
        end

        $display("test passed");
        $finish;
    end

endmodule

/* bench/pad_model.sv */
// behavioral pair of sega db9 pads on one shared select line, absent, 3-button or 6-button
`timescale 1ns/1ps

module pad_model (
    input  logic                clk,
    input  logic                split,
    input  logic                mdsel,
    input  pad_pkg::pad_kind_t  kind0,
    input  pad_pkg::pad_kind_t  kind1,
    input  pad_pkg::pad_word_t  btn0,
    input  pad_pkg::pad_word_t  btn1,
    output pad_pkg::pad_lines_t din
);
    import pad_pkg::*;

    // select must sit high this long before a pad restarts its sequence
    localparam int IDLE_RESET = 8 * LINE_CYCLES;

    // select falls seen since the last idle, both pads see the same line
    int   phase = 0;
    // cycles that select has been high
    int   high_cycles = 0;
    logic mdsel_q = 1'b1;

    // ==================================================================
    // select phase counter
    // ==================================================================

    // a fall is picked up one cycle late, well inside the line
    always @(posedge clk) begin
        mdsel_q <= mdsel;
        if (!mdsel) begin
            high_cycles <= 0;
            if (mdsel_q) begin
                phase <= phase + 1;
            end
        end else if (high_cycles >= IDLE_RESET) begin
            phase <= 0;
        end else begin
            high_cycles <= high_cycles + 1;
        end
    end

    // ==================================================================
    // connector lines
    // ==================================================================

    // what one pad puts on its six lines, active low
    function automatic pad_lines_t pad_response(input pad_kind_t k, input pad_word_t b,
                                                input logic sel, input int ph);
        pad_lines_t act;
        act = '0;
        if (k == NONE) begin
            return 6'h3f;
        end
        if (sel) begin
            if (k == SIX && ph == 3) begin
                // extra group on the third high phase
                act[0] = b[BIT_MODE];
                act[1] = b[BIT_X];
                act[2] = b[BIT_Y];
                act[3] = b[BIT_Z];
            end else begin
                act[0] = b[BIT_UP];
                act[1] = b[BIT_DOWN];
                act[2] = b[BIT_LEFT];
                act[3] = b[BIT_RIGHT];
            end
            act[4] = b[BIT_B];
            act[5] = b[BIT_C];
        end else begin
            if (k == SIX && ph == 3) begin
                // six-button signature, all four low lines pulled down
                act[3:0] = 4'hf;
            end else begin
                act[0]   = b[BIT_UP];
                act[1]   = b[BIT_DOWN];
                act[3:2] = 2'b11;
            end
            act[4] = b[BIT_A];
            act[5] = b[BIT_START];
        end
        return ~act;
    endfunction

    // split picks which pad drives the shared input
    assign din = split ? pad_response(kind1, btn1, mdsel, phase)
                       : pad_response(kind0, btn0, mdsel, phase);

endmodule

/* design/pad_port_top.sv */
// two-port db9 pad reader top, line tick feeding the scanner and the press detector
`timescale 1ns/1ps

module pad_port_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                scan,
    input  pad_pkg::pad_lines_t din,
    output logic                split,
    output logic                mdsel,
    output pad_pkg::pad_word_t  joy0,
    output pad_pkg::pad_word_t  joy1,
    output logic                sample,
    output pad_pkg::pad_word_t  press0,
    output pad_pkg::pad_word_t  press1,
    output logic                press_evt
);

    // one pulse per video line
    logic line_stb;

    // ==================================================================
    // line timing
    // ==================================================================

    line_tick u_line_tick (
        .clk      (clk),
        .rst      (rst),
        .line_stb (line_stb)
    );

    // ==================================================================
    // connector scan
    // ==================================================================

    // joy words change on the edge that raises sample
    pad_scanner u_pad_scanner (
        .clk      (clk),
        .rst      (rst),
        .line_stb (line_stb),
        .scan     (scan),
        .din      (din),
        .split    (split),
        .mdsel    (mdsel),
        .joy0     (joy0),
        .joy1     (joy1),
        .sample   (sample)
    );

    // ==================================================================
    // press events
    // ==================================================================

    // one cycle behind sample
    press_detect u_press_detect (
        .clk       (clk),
        .rst       (rst),
        .sample    (sample),
        .joy0      (joy0),
        .joy1      (joy1),
        .press0    (press0),
        .press1    (press1),
        .press_evt (press_evt)
    );

endmodule

/* design/press_detect.sv */
// newly-pressed detector that compares each published sample against the previous one per port
`timescale 1ns/1ps

module press_detect (
    input  logic               clk,
    input  logic               rst,
    input  logic               sample,
    input  pad_pkg::pad_word_t joy0,
    input  pad_pkg::pad_word_t joy1,
    output pad_pkg::pad_word_t press0,
    output pad_pkg::pad_word_t press1,
    output logic               press_evt
);
    import pad_pkg::*;

    // last sample seen on each port
    pad_word_t prev0;
    pad_word_t prev1;

    // bits that went from released to pressed
    function automatic pad_word_t rising(input pad_word_t cur, input pad_word_t old);
        return cur & ~old;
    endfunction

    // ==================================================================
    // edge detect on the button words
    // ==================================================================

    // prev words start at zero so held buttons show up on the first sample
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev0     <= '0;
            prev1     <= '0;
            press0    <= '0;
            press1    <= '0;
            press_evt <= 1'b0;
        end else begin
            press_evt <= sample;
            if (sample) begin
                press0 <= rising(joy0, prev0);
                press1 <= rising(joy1, prev1);
                prev0  <= joy0;
                prev1  <= joy1;
            end
        end
    end

    // masks hold until the next sample and the consumer latches on press_evt

    // ==================================================================
    // checks
    // ==================================================================

    // sample is a single-cycle strobe so each press is reported once
    a_sample_single : assert property (
        @(posedge clk) disable iff (rst)
        sample |=> !sample
    );

endmodule

/* design/pad_scanner.sv */
// db9 scanner for two sega pads on a shared select line that detects pad type and gathers buttons
`timescale 1ns/1ps

module pad_scanner (
    input  logic                clk,
    input  logic                rst,
    input  logic                line_stb,
    input  logic                scan,
    input  pad_pkg::pad_lines_t din,
    output logic                split,
    output logic                mdsel,
    output pad_pkg::pad_word_t  joy0,
    output pad_pkg::pad_word_t  joy1,
    output logic                sample
);
    import pad_pkg::*;

    // line position inside the 64-line scan
    line_cnt_t  cnt;
    // raw gather words per port in connector order
    // 5..0  lines 5..0 from the first high phase (C, B, directions)
    // 7..6  lines 5..4 from a low phase (start, A)
    // 11..8 lines 3..0 from the six-button high phase (Z, Y, X, mode)
    pad_word_t  raw [2];
    // pad type found so far on each port
    pad_kind_t  kind [2];
    // set after publication to keep split and mdsel parked until wrap
    logic       locked;
    // active-high view of the connector
    pad_lines_t pressed;

    assign pressed = ~din;

    // ==================================================================
    // raw to published layout
    // ==================================================================

    function automatic pad_word_t sort_raw(input pad_word_t r);
        pad_word_t w;
        w            = '0;
        w[BIT_UP]    = r[0];
        w[BIT_DOWN]  = r[1];
        w[BIT_LEFT]  = r[2];
        w[BIT_RIGHT] = r[3];
        w[BIT_B]     = r[4];
        w[BIT_C]     = r[5];
        w[BIT_A]     = r[6];
        w[BIT_START] = r[7];
        w[BIT_MODE]  = r[8];
        w[BIT_X]     = r[9];
        w[BIT_Y]     = r[10];
        w[BIT_Z]     = r[11];
        return w;
    endfunction

    // ==================================================================
    // scan sequencer
    // ==================================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            raw[0]  <= '0;
            raw[1]  <= '0;
            kind[0] <= NONE;
            kind[1] <= NONE;
            locked  <= 1'b0;
            split   <= 1'b1;
            mdsel   <= 1'b1;
            joy0    <= '0;
            joy1    <= '0;
            sample  <= 1'b0;
        end else begin
            // split follows cnt[0] and mdsel cnt[1] one cycle behind the counter
            if (!scan || locked) begin
                split <= 1'b1;
                mdsel <= 1'b1;
            end else begin
                split <= cnt[0];
                mdsel <= cnt[1];
            end

            sample <= scan && line_stb && (cnt == SAMPLE_LINE);

            if (!scan) begin
                // scanning off so start over from line 0
                cnt     <= '0;
                raw[0]  <= '0;
                raw[1]  <= '0;
                kind[0] <= NONE;
                kind[1] <= NONE;
                locked  <= 1'b0;
            end else if (line_stb) begin
                cnt <= cnt + 1'b1;
                if (cnt == SAMPLE_LINE) begin
                    // publish and clear for the next scan
                    locked  <= 1'b1;
                    joy0    <= sort_raw(raw[0]);
                    joy1    <= sort_raw(raw[1]);
                    raw[0]  <= '0;
                    raw[1]  <= '0;
                    kind[0] <= NONE;
                    kind[1] <= NONE;
                end else begin
                    if (cnt == line_cnt_t'(SCAN_LINES - 1)) begin
                        locked <= 1'b0;
                    end
                    // din answers the split/mdsel driven during this line
                    if (cnt < GATHER_LIMIT) begin
                        if (!mdsel) begin
                            if (pressed[3:0] == 4'hf) begin
                                // third low phase of a six-button pad
                                kind[split] <= SIX;
                            end else if (pressed[3:2] == 2'b11) begin
                                // left and right pulled low with start and A on 5..4
                                kind[split]      <= THREE;
                                raw[split][7:6]  <= pressed[5:4];
                            end
                        end else begin
                            // extra buttons where the last high phase before publish wins
                            if (kind[split] == SIX) begin
                                raw[split][11:8] <= pressed[3:0];
                            end
                            // first high phase per port carries C, B and directions
                            if (cnt < DIRECT_LIMIT) begin
                                raw[split][5:0] <= pressed;
                            end
                        end
                    end
                end
            end
        end
    end

    // ==================================================================
    // checks
    // ==================================================================

    // connector lines only toggle while scanning and before the sample line
    a_idle_high : assert property (
        @(posedge clk) disable iff (rst)
        (!split || !mdsel) |-> ($past(scan) && ($past(cnt) < SAMPLE_LINE))
    );

    // publication lands the cycle after the sample-line strobe with the connector locked
    a_sample_after_stb : assert property (
        @(posedge clk) disable iff (rst)
        sample |-> (locked && (cnt == SAMPLE_LINE + 1'b1) && !line_stb)
    );

endmodule

/* design/line_tick.sv */
// line-rate strobe generator, one clk-wide pulse per video line
`timescale 1ns/1ps

module line_tick (
    input  logic clk,
    input  logic rst,
    output logic line_stb
);
    import pad_pkg::*;

    // position inside the current line
    tick_cnt_t cnt;

    // ==================================================================
    // free-running line counter
    // ==================================================================

    // stands in for the hsync enable of a video timing block
    // strobe is registered, so it lands on the edge where cnt wraps
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            line_stb <= 1'b0;
        end else begin
            if (cnt == tick_cnt_t'(LINE_CYCLES - 1)) begin
                cnt      <= '0;
                line_stb <= 1'b1;
            end else begin
                cnt      <= cnt + 1'b1;
                line_stb <= 1'b0;
            end
        end
    end

    // ==================================================================
    // checks
    // ==================================================================

    // a line is always longer than one cycle
    a_stb_single : assert property (
        @(posedge clk) disable iff (rst)
        line_stb |=> !line_stb
    );

endmodule

/* design/pad_pkg.sv */
// shared constants, button layout and types for the two-port db9 pad reader
package pad_pkg;

    // ==================================================================
    // line timing
    // ==================================================================

    // clk cycles per video line, short here so a scan cycle stays small
    localparam int LINE_CYCLES = 16;
    localparam int TICK_W      = $clog2(LINE_CYCLES);
    typedef logic [TICK_W-1:0] tick_cnt_t;

    // ==================================================================
    // scan cycle
    // ==================================================================

    // lines in one full scan, the counter wraps here
    localparam int SCAN_LINES = 64;
    typedef logic [5:0] line_cnt_t;

    // results publish on this line, then the outputs park high
    localparam line_cnt_t SAMPLE_LINE  = 6'd15;
    // pad lines are only read below this count
    localparam line_cnt_t GATHER_LIMIT = 6'd14;
    // directions and B/C only come from the first high phase
    localparam line_cnt_t DIRECT_LIMIT = 6'd4;

    // raw connector lines, active low
    // 0 up, 1 down, 2 left, 3 right, 4 B or A, 5 C or start
    typedef logic [5:0] pad_lines_t;

    // published button word, active high
    typedef logic [11:0] pad_word_t;
    localparam int BIT_UP    = 0;
    localparam int BIT_DOWN  = 1;
    localparam int BIT_LEFT  = 2;
    localparam int BIT_RIGHT = 3;
    localparam int BIT_A     = 4;
    localparam int BIT_B     = 5;
    localparam int BIT_C     = 6;
    localparam int BIT_X     = 7;
    localparam int BIT_Y     = 8;
    localparam int BIT_Z     = 9;
    localparam int BIT_START = 10;
    localparam int BIT_MODE  = 11;

    // pad type seen during a scan
    typedef enum logic [1:0] {NONE = 2'd0, THREE = 2'd1, SIX = 2'd2} pad_kind_t;

endpackage
